//--- flist.f
+incdir+rtl
rtl/mandel_pkg.sv
rtl/pixel_dispatcher.sv
rtl/escape_iterator.sv
rtl/result_writer.sv
rtl/mandel_renderer_top.sv
verification/mandel_renderer_tb.sv

//--- rtl/escape_iterator.sv
`timescale 1ns/1ps
`default_nettype none

`include "mandel_config.svh"

module escape_iterator (
	input logic clk,
	input logic reset,
	input logic pixel_valid,
	input mandel_pkg::fixed_t c_re,
	input mandel_pkg::fixed_t c_im,
	input mandel_pkg::pixel_addr_t pixel_addr_in,
	input logic result_ready,
	output logic pixel_ready,
	output logic result_valid,
	output mandel_pkg::iter_count_t result_count,
	output mandel_pkg::pixel_addr_t result_addr
);

	localparam int prod_width = 2 * `MANDEL_FIX_WIDTH;
	// Top kept bit of the 8.46 product
	localparam int prod_msb = `MANDEL_FIX_FRAC + `MANDEL_FIX_WIDTH - 2;

	// Escape bounds in 4.23
	localparam mandel_pkg::fixed_t two_fix = 2 << `MANDEL_FIX_FRAC;
	localparam mandel_pkg::fixed_t four_fix = 4 << `MANDEL_FIX_FRAC;
	localparam mandel_pkg::iter_count_t count_limit = `MANDEL_ITER_MAX - 1;

	mandel_pkg::iter_state_e state;

	// Current z and the latched c
	mandel_pkg::fixed_t zr;
	mandel_pkg::fixed_t zi;
	mandel_pkg::fixed_t cr_q;
	mandel_pkg::fixed_t ci_q;

	// Full-width products
	logic signed [prod_width-1:0] zr_zr_full;
	logic signed [prod_width-1:0] zi_zi_full;
	logic signed [prod_width-1:0] zr_zi_full;

	mandel_pkg::fixed_t zr_sq;
	mandel_pkg::fixed_t zi_sq;
	mandel_pkg::fixed_t zr_zi;
	mandel_pkg::fixed_t zr_next;
	mandel_pkg::fixed_t zi_next;
	mandel_pkg::fixed_t mag_sq;
	logic escape;

	//////////////////////////////
	// z^2 + c datapath
	//////////////////////////////

	assign zr_zr_full = zr * zr;
	assign zi_zi_full = zi * zi;
	assign zr_zi_full = zr * zi;

	// Back to 4.23, sign bit plus the bits around the binary point
	assign zr_sq = {zr_zr_full[prod_width-1], zr_zr_full[prod_msb:`MANDEL_FIX_FRAC]};
	assign zi_sq = {zi_zi_full[prod_width-1], zi_zi_full[prod_msb:`MANDEL_FIX_FRAC]};
	assign zr_zi = {zr_zi_full[prod_width-1], zr_zi_full[prod_msb:`MANDEL_FIX_FRAC]};

	assign zr_next = zr_sq - zi_sq + cr_q;
	assign zi_next = (zr_zi <<< 1) + ci_q;
	assign mag_sq = zr_sq + zi_sq;

	// |z|^2 over 4, a component past +-2, or out of iterations
	assign escape = (mag_sq > four_fix)
		|| (result_count == count_limit)
		|| (zr_next > two_fix)
		|| (zr_next < -two_fix)
		|| (zi_next > two_fix)
		|| (zi_next < -two_fix);

	//////////////////////////////
	// Control FSM
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mandel_pkg::IDLE;
		end else begin
			case (state)
				mandel_pkg::IDLE: if (pixel_valid) state <= mandel_pkg::CALC;
				mandel_pkg::CALC: if (escape) state <= mandel_pkg::DONE;
				// Held until the writer takes the result
				mandel_pkg::DONE: if (result_ready) state <= mandel_pkg::IDLE;
				default: state <= mandel_pkg::IDLE;
			endcase
		end
	end

	// Iteration registers
	always_ff @(posedge clk) begin
		case (state)
			mandel_pkg::IDLE: begin
				if (pixel_valid) begin
					cr_q <= c_re;
					ci_q <= c_im;
					zr <= '0;
					zi <= '0;
					result_count <= '0;
					result_addr <= pixel_addr_in;
				end
			end
			mandel_pkg::CALC: begin
				zr <= zr_next;
				zi <= zi_next;
				result_count <= result_count + 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign pixel_ready = (state == mandel_pkg::IDLE);
	assign result_valid = (state == mandel_pkg::DONE);

endmodule

`default_nettype wire

//--- rtl/mandel_config.svh
`ifndef MANDEL_CONFIG_SVH
`define MANDEL_CONFIG_SVH

//////////////////////////////
// Renderer sizing
//////////////////////////////

// Iterators in the bank
`define MANDEL_NUM_ITERATORS 4

// Escape-time iteration limit
`define MANDEL_ITER_MAX 1000

//////////////////////////////
// Fixed-point format
//////////////////////////////

// Signed 4.23 values
`define MANDEL_FIX_WIDTH 27
`define MANDEL_FIX_FRAC 23

// Pixel step at zoom 0, about 0.00464 per pixel
`define MANDEL_BASE_STEP 39000

//////////////////////////////
// Frame buffer and controls
//////////////////////////////

// Enough for a 640 x 480 frame
`define MANDEL_ADDR_WIDTH 19

// Zoom levels 0 to 31
`define MANDEL_ZOOM_WIDTH 5

`endif

//--- rtl/mandel_pkg.sv
`default_nettype none

`include "mandel_config.svh"

package mandel_pkg;

	//////////////////////////////
	// Datapath types
	//////////////////////////////

	// Signed 4.23 fixed point
	typedef logic signed [`MANDEL_FIX_WIDTH-1:0] fixed_t;

	// Holds counts up to the iteration limit
	typedef logic [$clog2(`MANDEL_ITER_MAX):0] iter_count_t;

	// Frame-buffer address, row * width + column
	typedef logic [`MANDEL_ADDR_WIDTH-1:0] pixel_addr_t;

	// RRRGGGBB
	typedef logic [7:0] color_t;

	//////////////////////////////
	// State encodings
	//////////////////////////////

	// Escape iterator FSM
	typedef enum logic [1:0] {
		IDLE,
		CALC,
		DONE
	} iter_state_e;

	// Frame dispatcher FSM
	typedef enum logic [1:0] {
		DISP_IDLE,
		DISP_ISSUE,
		DISP_DRAIN,
		DISP_DONE
	} disp_state_e;

endpackage

`default_nettype wire

//--- rtl/mandel_renderer_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mandel_config.svh"

module mandel_renderer_top #(
	parameter int frame_width = 640,
	parameter int frame_height = 480
) (
	input logic clk,
	input logic reset,
	input logic start,
	input mandel_pkg::fixed_t x_start,
	input mandel_pkg::fixed_t y_start,
	input logic [`MANDEL_ZOOM_WIDTH-1:0] zoom,
	output logic mem_we,
	output mandel_pkg::pixel_addr_t mem_addr,
	output mandel_pkg::color_t mem_data,
	output logic done
);

	localparam mandel_pkg::fixed_t base_step = `MANDEL_BASE_STEP;

	// Zoomed pixel step, same for x and y
	mandel_pkg::fixed_t step;

	// Dispatcher to iterators
	logic [`MANDEL_NUM_ITERATORS-1:0] pixel_valid;
	logic [`MANDEL_NUM_ITERATORS-1:0] pixel_ready;
	mandel_pkg::fixed_t c_re;
	mandel_pkg::fixed_t c_im;
	mandel_pkg::pixel_addr_t pixel_addr;

	// Iterators to writer
	logic [`MANDEL_NUM_ITERATORS-1:0] result_valid;
	logic [`MANDEL_NUM_ITERATORS-1:0] result_ready;
	mandel_pkg::iter_count_t result_count [`MANDEL_NUM_ITERATORS];
	mandel_pkg::pixel_addr_t result_addr [`MANDEL_NUM_ITERATORS];

	logic write_done;

	// Each zoom level halves the step
	assign step = base_step >>> zoom;

	// Completed writes feed the frame counter
	assign write_done = mem_we;

	//////////////////////////////
	// Frame walk
	//////////////////////////////

	pixel_dispatcher #(
		.frame_width(frame_width),
		.frame_height(frame_height)
	) dispatcher_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.x_start(x_start),
		.y_start(y_start),
		.step(step),
		.pixel_ready(pixel_ready),
		.write_done(write_done),
		.pixel_valid(pixel_valid),
		.c_re(c_re),
		.c_im(c_im),
		.pixel_addr(pixel_addr),
		.done(done)
	);

	// Iterator bank, coordinate bus shared by all
	for (genvar k = 0; k < `MANDEL_NUM_ITERATORS; k++) begin : gen_iter
		escape_iterator iterator_i (
			.clk(clk),
			.reset(reset),
			.pixel_valid(pixel_valid[k]),
			.c_re(c_re),
			.c_im(c_im),
			.pixel_addr_in(pixel_addr),
			.result_ready(result_ready[k]),
			.pixel_ready(pixel_ready[k]),
			.result_valid(result_valid[k]),
			.result_count(result_count[k]),
			.result_addr(result_addr[k])
		);
	end

	// Colour mapping and write port
	result_writer writer_i (
		.clk(clk),
		.reset(reset),
		.result_valid(result_valid),
		.result_count(result_count),
		.result_addr(result_addr),
		.result_ready(result_ready),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_data(mem_data)
	);

endmodule

`default_nettype wire

//--- rtl/pixel_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

`include "mandel_config.svh"

module pixel_dispatcher #(
	parameter int frame_width = 640,
	parameter int frame_height = 480
) (
	input logic clk,
	input logic reset,
	input logic start,
	input mandel_pkg::fixed_t x_start,
	input mandel_pkg::fixed_t y_start,
	input mandel_pkg::fixed_t step,
	input logic [`MANDEL_NUM_ITERATORS-1:0] pixel_ready,
	input logic write_done,
	output logic [`MANDEL_NUM_ITERATORS-1:0] pixel_valid,
	output mandel_pkg::fixed_t c_re,
	output mandel_pkg::fixed_t c_im,
	output mandel_pkg::pixel_addr_t pixel_addr,
	output logic done
);

	localparam int total_pixels = frame_width * frame_height;
	localparam int col_width = $clog2(frame_width + 1);
	localparam int row_width = $clog2(frame_height + 1);

	mandel_pkg::disp_state_e state;
	logic [col_width-1:0] col;
	logic [row_width-1:0] row;
	mandel_pkg::pixel_addr_t write_count;
	// Frame origin and step, latched at start
	mandel_pkg::fixed_t x_origin;
	mandel_pkg::fixed_t step_q;
	logic accept;
	logic transfer;
	logic found;
	logic end_of_row;
	logic last_pixel;
	logic last_write;

	// New frame only from idle or after the previous one finished
	assign accept = start && (state == mandel_pkg::DISP_IDLE || state == mandel_pkg::DISP_DONE);

	assign end_of_row = (col == col_width'(frame_width - 1));
	assign last_pixel = end_of_row && (row == row_width'(frame_height - 1));
	assign last_write = write_done && (write_count == mandel_pkg::pixel_addr_t'(total_pixels - 1));

	//////////////////////////////
	// Offer to lowest free iterator
	//////////////////////////////

	always_comb begin
		pixel_valid = '0;
		found = 1'b0;
		for (int k = 0; k < `MANDEL_NUM_ITERATORS; k++) begin
			if (state == mandel_pkg::DISP_ISSUE && pixel_ready[k] && !found) begin
				pixel_valid[k] = 1'b1;
				found = 1'b1;
			end
		end
	end

	assign transfer = |(pixel_valid & pixel_ready);

	// Frame FSM and counters
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mandel_pkg::DISP_IDLE;
			col <= '0;
			row <= '0;
			pixel_addr <= '0;
			write_count <= '0;
		end else begin
			if (accept) begin
				state <= mandel_pkg::DISP_ISSUE;
				col <= '0;
				row <= '0;
				pixel_addr <= '0;
				write_count <= '0;
			end else begin
				// Raster walk, one pixel per transfer
				if (transfer) begin
					pixel_addr <= pixel_addr + 1'b1;
					if (end_of_row) begin
						col <= '0;
						row <= row + 1'b1;
					end else begin
						col <= col + 1'b1;
					end
					// Nothing more to hand out
					if (last_pixel) begin
						state <= mandel_pkg::DISP_DRAIN;
					end
				end
				// Frame ends with its last frame-buffer write
				if (write_done) begin
					write_count <= write_count + 1'b1;
				end
				if (state == mandel_pkg::DISP_DRAIN && last_write) begin
					state <= mandel_pkg::DISP_DONE;
				end
			end
		end
	end

	//////////////////////////////
	// Complex coordinate stepping
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (accept) begin
			x_origin <= x_start;
			step_q <= step;
			c_re <= x_start;
			c_im <= y_start;
		end else if (transfer) begin
			if (end_of_row) begin
				// Back to left edge, one row down
				c_re <= x_origin;
				c_im <= c_im - step_q;
			end else begin
				c_re <= c_re + step_q;
			end
		end
	end

	assign done = (state == mandel_pkg::DISP_DONE);

endmodule

`default_nettype wire

//--- rtl/result_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mandel_config.svh"

module result_writer (
	input logic clk,
	input logic reset,
	input logic [`MANDEL_NUM_ITERATORS-1:0] result_valid,
	input mandel_pkg::iter_count_t result_count [`MANDEL_NUM_ITERATORS],
	input mandel_pkg::pixel_addr_t result_addr [`MANDEL_NUM_ITERATORS],
	output logic [`MANDEL_NUM_ITERATORS-1:0] result_ready,
	output logic mem_we,
	output mandel_pkg::pixel_addr_t mem_addr,
	output mandel_pkg::color_t mem_data
);

	localparam int sel_width = (`MANDEL_NUM_ITERATORS > 1) ? $clog2(`MANDEL_NUM_ITERATORS) : 1;

	//////////////////////////////
	// Palette in RRRGGGBB
	//////////////////////////////

	localparam mandel_pkg::color_t color_black = 8'b000_000_00;
	localparam mandel_pkg::color_t color_brown = 8'b011_001_00;
	localparam mandel_pkg::color_t color_tan = 8'b101_010_01;
	localparam mandel_pkg::color_t color_plum = 8'b011_001_01;
	localparam mandel_pkg::color_t color_navy = 8'b001_001_01;
	localparam mandel_pkg::color_t color_olive = 8'b011_010_10;
	localparam mandel_pkg::color_t color_teal = 8'b010_100_10;

	logic [sel_width-1:0] sel;
	logic found;

	// Coarse bands halving down from the limit
	function automatic mandel_pkg::color_t palette(input mandel_pkg::iter_count_t count);
		// Never escaped
		if (count >= `MANDEL_ITER_MAX - 1) begin
			return color_black;
		end else if (count >= (`MANDEL_ITER_MAX >> 2)) begin
			// Half and quarter bands share one colour
			return color_brown;
		end else if (count >= (`MANDEL_ITER_MAX >> 3)) begin
			return color_tan;
		end else if (count >= (`MANDEL_ITER_MAX >> 4)) begin
			return color_plum;
		end else if (count >= (`MANDEL_ITER_MAX >> 5)) begin
			return color_navy;
		end else if (count >= (`MANDEL_ITER_MAX >> 6)) begin
			return color_olive;
		end
		// Fast escapes all share one colour
		return color_teal;
	endfunction

	//////////////////////////////
	// Fixed-priority grant
	//////////////////////////////

	always_comb begin
		result_ready = '0;
		sel = '0;
		found = 1'b0;
		for (int k = 0; k < `MANDEL_NUM_ITERATORS; k++) begin
			if (result_valid[k] && !found) begin
				result_ready[k] = 1'b1;
				sel = sel_width'(k);
				found = 1'b1;
			end
		end
	end

	// Write strobe registered one cycle behind the grant
	always_ff @(posedge clk) begin
		if (reset) begin
			mem_we <= 1'b0;
		end else begin
			mem_we <= found;
		end
	end

	// Address and colour of the granted result
	always_ff @(posedge clk) begin
		if (found) begin
			mem_addr <= result_addr[sel];
			mem_data <= palette(result_count[sel]);
		end
	end

endmodule

`default_nettype wire

//--- verification/mandel_renderer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mandel_config.svh"

module mandel_renderer_tb;

	localparam int frame_width = 8;
	localparam int frame_height = 4;
	localparam int frame_pixels = frame_width * frame_height;
	localparam int num_views = 3;
	// x start, y start and zoom, then one colour per pixel
	localparam int view_words = 3 + frame_pixels;
	// Every pixel at the limit with no overlap
	localparam int frame_limit = frame_pixels * (`MANDEL_ITER_MAX + 4);
	localparam int watchdog_ns = num_views * frame_pixels * `MANDEL_ITER_MAX * 20;

	logic clk;
	logic reset;
	logic start;
	mandel_pkg::fixed_t x_start;
	mandel_pkg::fixed_t y_start;
	logic [`MANDEL_ZOOM_WIDTH-1:0] zoom;
	logic mem_we;
	mandel_pkg::pixel_addr_t mem_addr;
	mandel_pkg::color_t mem_data;
	logic done;

	logic [31:0] testdata [num_views * view_words];
	logic [31:0] lfsr_state = 32'hfe15;

	// Frame record filled by the write monitor
	int active_view;
	int write_hits [frame_pixels];
	int write_total;
	int writes_at_rise;
	int done_rises;
	logic done_prev = 1'b0;

	int error_count;
	int errors_at_test_start;
	int tests_run;
	int tests_failed;
	string test_name;

	mandel_renderer_top #(
		.frame_width(frame_width),
		.frame_height(frame_height)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.x_start(x_start),
		.y_start(y_start),
		.zoom(zoom),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.done(done)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Bound on the whole run
	initial begin
		#(watchdog_ns);
		$display("ERROR: watchdog expired after %0d ns, the run never finished", watchdog_ns);
		$display("FAIL: see errors above");
		$finish;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAILED %s at %0t: got %0h, expected %0h", name, $time, got, expected);
			error_count++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		error_count++;
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = (value << 1) | lfsr_state[0];
		end
	endtask

	// Fields of one view in the data file
	function automatic mandel_pkg::fixed_t view_x(input int view);
		return mandel_pkg::fixed_t'(testdata[view * view_words][`MANDEL_FIX_WIDTH-1:0]);
	endfunction

	function automatic mandel_pkg::fixed_t view_y(input int view);
		return mandel_pkg::fixed_t'(testdata[view * view_words + 1][`MANDEL_FIX_WIDTH-1:0]);
	endfunction

	function automatic logic [`MANDEL_ZOOM_WIDTH-1:0] view_zoom(input int view);
		return testdata[view * view_words + 2][`MANDEL_ZOOM_WIDTH-1:0];
	endfunction

	function automatic logic [7:0] expected_color(input int view, input int addr);
		return testdata[view * view_words + 3 + addr][7:0];
	endfunction

	task automatic test_begin(input string name);
		test_name = name;
		errors_at_test_start = error_count;
	endtask

	task automatic test_end();
		tests_run++;
		if (error_count == errors_at_test_start) begin
			$display("test %0d %s: passed", tests_run, test_name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, test_name,
				error_count - errors_at_test_start);
		end
	endtask

	task automatic clear_frame_record(input int view);
		active_view = view;
		write_total = 0;
		writes_at_rise = 0;
		done_rises = 0;
		for (int a = 0; a < frame_pixels; a++) begin
			write_hits[a] = 0;
		end
	endtask

	// One-cycle start with the view's coordinates
	task automatic pulse_start(input int view);
		@(posedge clk);
		start <= 1'b1;
		x_start <= view_x(view);
		y_start <= view_y(view);
		zoom <= view_zoom(view);
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic check_frame_record();
		for (int a = 0; a < frame_pixels; a++) begin
			if (write_hits[a] != 1) begin
				report_failure($sformatf("pixel %0d written %0d times instead of once",
					a, write_hits[a]));
			end
		end
		check_value("writes before done", writes_at_rise, frame_pixels);
		check_value("done rises", done_rises, 1);
	endtask

	// Full frame with an optional second start once writes begin
	task automatic render_frame(input int view, input int extra_view);
		int gap;
		int cycles;
		logic extra_sent;
		@(posedge clk);
		clear_frame_record(view);
		random_bits(3, gap);
		repeat (gap) @(posedge clk);
		pulse_start(view);
		@(negedge clk);
		check_value("done after start", done, 0);
		cycles = 0;
		extra_sent = (extra_view < 0);
		while (!done && cycles < frame_limit) begin
			if (!extra_sent && mem_we) begin
				// Frame still running here
				pulse_start(extra_view);
				extra_sent = 1'b1;
			end
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			report_failure($sformatf("frame of view %0d never raised done", view));
		end else begin
			repeat (4) @(posedge clk);
			check_frame_record();
		end
	endtask

	//////////////////////////////
	// Write port monitor
	//////////////////////////////

	always @(negedge clk) begin
		if (done && !done_prev) begin
			done_rises++;
			writes_at_rise = write_total;
		end
		done_prev = done;
		if (mem_we) begin
			if (done) begin
				report_failure("mem_we high while done is high");
			end
			if (mem_addr >= frame_pixels) begin
				report_failure($sformatf("write to address %0h outside the frame", mem_addr));
			end else begin
				write_hits[mem_addr]++;
				write_total++;
				check_value($sformatf("mem_data[%0d]", mem_addr), mem_data,
					expected_color(active_view, mem_addr));
			end
		end
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		int cycles;
		int differ;
		reset = 1'b1;
		start = 1'b0;
		x_start = '0;
		y_start = '0;
		zoom = '0;
		$readmemh("verification/mandel_testdata.txt", testdata);
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		if ($isunknown(testdata[num_views * view_words - 1])) begin
			report_failure("test data missing or short in verification/mandel_testdata.txt");
		end else begin
			test_begin("reset state");
			@(negedge clk);
			check_value("done", done, 0);
			check_value("mem_we", mem_we, 0);
			test_end();

			test_begin("view 0 at zoom 0");
			render_frame(0, -1);
			test_end();

			// Same start point with a finer step
			test_begin("view 1 at zoom 2");
			differ = 0;
			for (int a = 0; a < frame_pixels; a++) begin
				if (expected_color(0, a) != expected_color(1, a)) begin
					differ++;
				end
			end
			if (differ == 0) begin
				report_failure("view 1 colours equal view 0 colours, zoom not exercised");
			end
			check_value("view 1 x start", view_x(1), view_x(0));
			check_value("view 1 y start", view_y(1), view_y(0));
			check_value("view 1 zoom", view_zoom(1), 2);
			render_frame(1, -1);
			test_end();

			// Every pixel runs to the limit
			test_begin("view 2 inside the set");
			render_frame(2, -1);
			test_end();

			test_begin("start ignored mid-frame");
			render_frame(0, 2);
			render_frame(1, -1);
			test_end();

			test_begin("reset mid-frame");
			@(posedge clk);
			clear_frame_record(2);
			pulse_start(2);
			cycles = 0;
			@(negedge clk);
			while (!mem_we && cycles < frame_limit) begin
				@(negedge clk);
				cycles++;
			end
			if (!mem_we) begin
				report_failure("no write seen before the mid-frame reset");
			end
			@(posedge clk);
			reset <= 1'b1;
			@(posedge clk);
			@(negedge clk);
			check_value("mem_we in reset", mem_we, 0);
			check_value("done in reset", done, 0);
			@(posedge clk);
			reset <= 1'b0;
			render_frame(0, -1);
			test_end();
		end

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/mandel_testdata.txt
// Per view: x_start y_start zoom, fixed point 4.23 sign-extended to 32 bits
// then 4 frame rows of 8 expected RRRGGGBB colours, left to right
// View 0, row 0 ends exactly on c = -2
FEFBD598 00000000 00
52 52 52 52 52 52 52 00
52 52 52 52 52 52 52 52
52 52 52 52 52 52 52 52
52 52 52 52 52 52 52 52
// View 1, same start at zoom 2, whole frame left of -2
FEFBD598 00000000 02
52 52 52 52 52 52 52 52
52 52 52 52 52 52 52 52
52 52 52 52 52 52 52 52
52 52 52 52 52 52 52 52
// View 2, start -0.125 + 0.0625i, inside the main cardioid
FFF00000 00080000 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
